// File: exec_pkg.sv
// Shared widths and enums for the execute and memory pipeline; import into each module header
`default_nettype none

package exec_pkg;

  // Data and address word size
  localparam int word_width = 32;

  // Destination register index size
  localparam int reg_index_width = 5;

  // Operation codes presented by the issuer
  // Eight ALU opcodes first, memory opcodes after them
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sll,
    op_srl,
    op_load_word,
    op_load_byte,
    op_store_word,
    op_store_byte
  } alu_op_t;

  // Data memory controller states
  typedef enum logic [1:0] {
    mem_idle,
    mem_busy,
    mem_done
  } mem_state_t;

endpackage

`default_nettype wire

// File: alu.sv
// Combinational integer ALU used by the execute stage, gives a result and a zero flag
`default_nettype none

module alu
  import exec_pkg::*;
(
  input  alu_op_t               op,
  input  logic [word_width-1:0] a,
  input  logic [word_width-1:0] b,
  output logic [word_width-1:0] result,
  output logic                  zero
);

  // Shift amount takes the low bits of b
  localparam int shamt_width = $clog2(word_width);

  logic [shamt_width-1:0] shamt;

  assign shamt = b[shamt_width-1:0];

  always_comb
  begin
    case (op)
      op_add: result = a + b;
      op_sub: result = a - b;
      op_and: result = a & b;
      op_or:  result = a | b;
      op_xor: result = a ^ b;
      // Signed compare, result is 0 or 1
      op_slt: result = {{(word_width-1){1'b0}}, $signed(a) < $signed(b)};
      op_sll: result = a << shamt;
      // Logical shift, zeros come in from the top
      op_srl: result = a >> shamt;
      // Loads and stores use the sum as effective address
      op_load_word,
      op_load_byte,
      op_store_word,
      op_store_byte: result = a + b;
      default: result = '0;
    endcase
  end

  // Zero flag follows the final result
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: execute_stage.sv
// Execute stage: picks the second operand, runs the ALU and decodes memory control bits
`default_nettype none

module execute_stage
  import exec_pkg::*;
(
  input  alu_op_t               op,
  input  logic [word_width-1:0] rs1_value,
  input  logic [word_width-1:0] rs2_value,
  input  logic [word_width-1:0] imm,
  input  logic                  use_imm,
  output logic [word_width-1:0] alu_result,
  output logic                  alu_zero,
  output logic                  mem_access,
  output logic                  mem_write,
  output logic                  byte_op,
  output logic                  mem_to_reg
);

  logic [word_width-1:0] operand_b;

  // Memory control decode
  always_comb
  begin
    mem_access = 1'b0;
    mem_write  = 1'b0;
    byte_op    = 1'b0;
    mem_to_reg = 1'b0;
    case (op)
      op_load_word:
      begin
        mem_access = 1'b1;
        mem_to_reg = 1'b1;
      end
      op_load_byte:
      begin
        mem_access = 1'b1;
        mem_to_reg = 1'b1;
        byte_op    = 1'b1;
      end
      op_store_word:
      begin
        mem_access = 1'b1;
        mem_write  = 1'b1;
      end
      op_store_byte:
      begin
        mem_access = 1'b1;
        mem_write  = 1'b1;
        byte_op    = 1'b1;
      end
      default: ;
    endcase
  end

  // Address offset always comes from the immediate
  // rs2_value then only carries store data
  assign operand_b = (use_imm || mem_access) ? imm : rs2_value;

  alu alu_i (
    .op     (op),
    .a      (rs1_value),
    .b      (operand_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

endmodule

`default_nettype wire

// File: ex_mem_reg.sv
// Execute-to-memory pipeline register; locks during a memory access and stalls the issuer
`default_nettype none

module ex_mem_reg
  import exec_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       active,
  input  alu_op_t                    op,
  input  logic [reg_index_width-1:0] rd,
  input  logic                       reg_write,
  input  logic [word_width-1:0]      alu_result,
  input  logic                       alu_zero,
  input  logic                       mem_access,
  input  logic                       mem_write,
  input  logic                       byte_op,
  input  logic                       mem_to_reg,
  input  logic [word_width-1:0]      rs2_value,
  input  logic                       unlock,
  output logic                       stall,
  output logic                       entry_valid,
  output alu_op_t                    op_out,
  output logic [reg_index_width-1:0] rd_out,
  output logic                       reg_write_out,
  output logic [word_width-1:0]      alu_result_out,
  output logic                       alu_zero_out,
  output logic                       mem_access_out,
  output logic                       mem_write_out,
  output logic                       byte_op_out,
  output logic                       mem_to_reg_out,
  output logic [word_width-1:0]      store_data_out
);

  logic lock;
  logic take;

  // Single acceptance point for the whole pipeline
  assign take  = active && !lock;
  assign stall = lock;

  // Control state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      lock        <= 1'b0;
      entry_valid <= 1'b0;
    end
    else
    begin
      // One-cycle pulse per accepted operation
      entry_valid <= take;
      // Memory side completion releases the lock
      if (unlock)
        lock <= 1'b0;
      else if (take && mem_access)
        lock <= 1'b1;
    end
  end

  // Payload stays put while locked, mem_stage reads it at completion
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      op_out         <= op;
      rd_out         <= rd;
      reg_write_out  <= reg_write;
      alu_result_out <= alu_result;
      alu_zero_out   <= alu_zero;
      mem_access_out <= mem_access;
      mem_write_out  <= mem_write;
      byte_op_out    <= byte_op;
      mem_to_reg_out <= mem_to_reg;
      store_data_out <= rs2_value;
    end
  end

endmodule

`default_nettype wire

// File: data_mem.sv
// Word-organised data memory with byte-lane writes; req pulse in, done pulse mem_latency later
`default_nettype none

module data_mem
  import exec_pkg::*;
#(
  parameter int mem_latency = 3,
  parameter int mem_words   = 64
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  write,
  input  logic                  byte_op,
  input  logic [word_width-1:0] addr,
  input  logic [word_width-1:0] write_data,
  output logic                  done,
  output logic [word_width-1:0] read_data
);

  localparam int index_width = $clog2(mem_words);
  localparam int cnt_width   = $clog2(mem_latency + 1);

  logic [word_width-1:0]  mem [mem_words];
  mem_state_t             state;
  logic [cnt_width-1:0]   cnt;
  // Request latched at req
  logic [index_width-1:0] word_q;
  logic [1:0]             lane_q;
  logic                   write_q;
  logic                   byte_q;
  logic [word_width-1:0]  wdata_q;

  // Latency counter and state machine
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= mem_idle;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        mem_idle:
          if (req)
          begin
            cnt   <= cnt_width'(1);
            // Single-cycle latency skips the busy state
            state <= (mem_latency <= 1) ? mem_done : mem_busy;
          end
        mem_busy:
          if (cnt == cnt_width'(mem_latency - 1))
            state <= mem_done;
          else
            cnt <= cnt + 1'b1;
        default:
          state <= mem_idle;
      endcase
    end
  end

  // Low two address bits pick the byte lane
  always_ff @(posedge clk)
  begin
    if (state == mem_idle && req)
    begin
      word_q  <= addr[2 +: index_width];
      lane_q  <= addr[1:0];
      write_q <= write;
      byte_q  <= byte_op;
      wdata_q <= write_data;
    end
  end

  // Write lands at the end of the done cycle
  always_ff @(posedge clk)
  begin
    if (state == mem_done && write_q)
    begin
      if (byte_q)
        mem[word_q][{lane_q, 3'b000} +: 8] <= wdata_q[7:0];
      else
        mem[word_q] <= wdata_q;
    end
  end

  assign done      = (state == mem_done);
  // Whole word returned, valid while done is high
  assign read_data = mem[word_q];

endmodule

`default_nettype wire

// File: mem_stage.sv
// Memory stage: runs loads and stores on data_mem, unlocks the register and registers writeback
`default_nettype none

module mem_stage
  import exec_pkg::*;
#(
  parameter int mem_latency = 3,
  parameter int mem_words   = 64
)
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       entry_valid,
  input  logic [reg_index_width-1:0] rd,
  input  logic                       reg_write,
  input  logic [word_width-1:0]      alu_result,
  input  logic                       alu_zero,
  input  logic                       mem_access,
  input  logic                       mem_write,
  input  logic                       byte_op,
  input  logic                       mem_to_reg,
  input  logic [word_width-1:0]      store_data,
  input  logic [word_width-1:0]      read_data,
  input  logic                       done,
  output logic                       req,
  output logic                       write,
  output logic                       byte_op_mem,
  output logic [word_width-1:0]      addr,
  output logic [word_width-1:0]      write_data,
  output logic                       unlock,
  output logic                       wb_valid,
  output logic [reg_index_width-1:0] wb_rd,
  output logic [word_width-1:0]      wb_data,
  output logic                       wb_write,
  output logic                       wb_zero
);

  // Byte address bits that reach the memory
  localparam int addr_bits = $clog2(mem_words) + 2;
  localparam int cnt_width = $clog2(mem_latency + 1);

  logic [cnt_width-1:0]  wait_cnt;
  logic [7:0]            load_byte;
  logic [word_width-1:0] load_value;
  logic                  alu_wb;

  assign alu_wb = entry_valid && !mem_access;

  // Request goes out in the same cycle the entry shows up
  assign req         = entry_valid && mem_access;
  assign write       = mem_write;
  assign byte_op_mem = byte_op;
  assign addr        = {{(word_width-addr_bits){1'b0}}, alu_result[addr_bits-1:0]};
  assign write_data  = store_data;

  // Countdown to the expected done, zero when nothing pending
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wait_cnt <= '0;
    else if (req)
      wait_cnt <= cnt_width'(mem_latency);
    else if (unlock)
      wait_cnt <= '0;
    else if (wait_cnt > cnt_width'(1))
      wait_cnt <= wait_cnt - 1'b1;
  end

  // Completion of our own access only
  assign unlock = done && (wait_cnt == cnt_width'(1));

  // Addressed lane, zero extended
  assign load_byte  = read_data[{alu_result[1:0], 3'b000} +: 8];
  assign load_value = byte_op ? {{(word_width-8){1'b0}}, load_byte} : read_data;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= alu_wb || unlock;
  end

  // Writeback payload
  // Stores report their address and never write a register
  always_ff @(posedge clk)
  begin
    if (alu_wb || unlock)
    begin
      wb_rd    <= rd;
      wb_zero  <= alu_zero;
      wb_write <= reg_write && !mem_write;
      wb_data  <= (unlock && mem_to_reg) ? load_value : alu_result;
    end
  end

endmodule

`default_nettype wire

// File: exec_mem_top.sv
// Top level of the execute and memory pipeline; wires the stages and sets memory parameters
`default_nettype none

module exec_mem_top
  import exec_pkg::*;
#(
  parameter int mem_latency = 3,
  parameter int mem_words   = 64
)
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Issue port
  input  logic                       active,
  input  alu_op_t                    op,
  input  logic [word_width-1:0]      rs1_value,
  input  logic [word_width-1:0]      rs2_value,
  input  logic [word_width-1:0]      imm,
  input  logic                       use_imm,
  input  logic [reg_index_width-1:0] rd,
  input  logic                       reg_write,
  output logic                       stall,
  // Writeback port
  output logic                       wb_valid,
  output logic [reg_index_width-1:0] wb_rd,
  output logic [word_width-1:0]      wb_data,
  output logic                       wb_write,
  output logic                       wb_zero
);

  // Execute stage outputs
  logic [word_width-1:0]      ex_result;
  logic                       ex_zero;
  logic                       ex_mem_access;
  logic                       ex_mem_write;
  logic                       ex_byte_op;
  logic                       ex_mem_to_reg;
  // Registered entry
  logic                       entry_valid;
  logic [reg_index_width-1:0] m_rd;
  logic                       m_reg_write;
  logic [word_width-1:0]      m_result;
  logic                       m_zero;
  logic                       m_mem_access;
  logic                       m_mem_write;
  logic                       m_byte_op;
  logic                       m_mem_to_reg;
  logic [word_width-1:0]      m_store_data;
  logic                       unlock;
  // Memory request and response
  logic                       dm_req;
  logic                       dm_write;
  logic                       dm_byte_op;
  logic [word_width-1:0]      dm_addr;
  logic [word_width-1:0]      dm_wdata;
  logic                       dm_done;
  logic [word_width-1:0]      dm_rdata;

  execute_stage execute_stage_i (
    .op         (op),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .imm        (imm),
    .use_imm    (use_imm),
    .alu_result (ex_result),
    .alu_zero   (ex_zero),
    .mem_access (ex_mem_access),
    .mem_write  (ex_mem_write),
    .byte_op    (ex_byte_op),
    .mem_to_reg (ex_mem_to_reg)
  );

  // Opcode copy is not needed past this point
  ex_mem_reg ex_mem_reg_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .active         (active),
    .op             (op),
    .rd             (rd),
    .reg_write      (reg_write),
    .alu_result     (ex_result),
    .alu_zero       (ex_zero),
    .mem_access     (ex_mem_access),
    .mem_write      (ex_mem_write),
    .byte_op        (ex_byte_op),
    .mem_to_reg     (ex_mem_to_reg),
    .rs2_value      (rs2_value),
    .unlock         (unlock),
    .stall          (stall),
    .entry_valid    (entry_valid),
    .op_out         (),
    .rd_out         (m_rd),
    .reg_write_out  (m_reg_write),
    .alu_result_out (m_result),
    .alu_zero_out   (m_zero),
    .mem_access_out (m_mem_access),
    .mem_write_out  (m_mem_write),
    .byte_op_out    (m_byte_op),
    .mem_to_reg_out (m_mem_to_reg),
    .store_data_out (m_store_data)
  );

  mem_stage #(
    .mem_latency (mem_latency),
    .mem_words   (mem_words)
  ) mem_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .entry_valid (entry_valid),
    .rd          (m_rd),
    .reg_write   (m_reg_write),
    .alu_result  (m_result),
    .alu_zero    (m_zero),
    .mem_access  (m_mem_access),
    .mem_write   (m_mem_write),
    .byte_op     (m_byte_op),
    .mem_to_reg  (m_mem_to_reg),
    .store_data  (m_store_data),
    .read_data   (dm_rdata),
    .done        (dm_done),
    .req         (dm_req),
    .write       (dm_write),
    .byte_op_mem (dm_byte_op),
    .addr        (dm_addr),
    .write_data  (dm_wdata),
    .unlock      (unlock),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_write    (wb_write),
    .wb_zero     (wb_zero)
  );

  data_mem #(
    .mem_latency (mem_latency),
    .mem_words   (mem_words)
  ) data_mem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (dm_req),
    .write      (dm_write),
    .byte_op    (dm_byte_op),
    .addr       (dm_addr),
    .write_data (dm_wdata),
    .done       (dm_done),
    .read_data  (dm_rdata)
  );

endmodule

`default_nettype wire

// File: tb_exec_mem.sv
// Self-checking testbench for exec_mem_top; replays exec_mem_input.txt and checks every writeback
`default_nettype none

module tb_exec_mem
  import exec_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_latency = 3;
  localparam int mem_words   = 64;
  // Cycle budgets for the wait loops
  localparam int stall_limit = 20;
  localparam int drain_limit = 40;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       active;
  alu_op_t                    op;
  logic [word_width-1:0]      rs1_value;
  logic [word_width-1:0]      rs2_value;
  logic [word_width-1:0]      imm;
  logic                       use_imm;
  logic [reg_index_width-1:0] rd;
  logic                       reg_write;
  logic                       stall;
  logic                       wb_valid;
  logic [reg_index_width-1:0] wb_rd;
  logic [word_width-1:0]      wb_data;
  logic                       wb_write;
  logic                       wb_zero;

  // Expected writebacks in issue order
  logic [word_width-1:0]      exp_data_q[$];
  logic                       exp_zero_q[$];
  logic [reg_index_width-1:0] exp_rd_q[$];
  logic                       exp_write_q[$];
  int                         exp_edge_q[$];
  // Entry popped by the monitor
  logic [word_width-1:0]      e_data;
  logic                       e_zero;
  logic [reg_index_width-1:0] e_rd;
  logic                       e_write;
  int                         e_edge;

  int cycle = 0;
  int seed;
  int value_errors;
  int timing_errors;
  int protocol_errors;
  int issued;
  int wb_count;
  bit timed_out;

  exec_mem_top #(
    .mem_latency (mem_latency),
    .mem_words   (mem_words)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .active    (active),
    .op        (op),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .imm       (imm),
    .use_imm   (use_imm),
    .rd        (rd),
    .reg_write (reg_write),
    .stall     (stall),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .wb_write  (wb_write),
    .wb_zero   (wb_zero)
  );

  always #4 clk = ~clk;

  // Rising edge count for the latency checks
  // Read 1 ns after an edge or at the falling edge
  always @(posedge clk)
    cycle <= cycle + 1;

  // Inputs change 1 ns after the rising edge
  task automatic next_drive_point();
    @(posedge clk);
    #1;
  endtask

  // Present one operation, hold it through stall, queue its expected writeback
  task automatic issue_op(input logic [3:0] code, input logic [reg_index_width-1:0] dst,
                          input logic wr, input logic [word_width-1:0] a,
                          input logic [word_width-1:0] b, input logic [word_width-1:0] im,
                          input logic sel, input logic [word_width-1:0] data, input logic zf);
    alu_op_t kind;
    logic    is_mem;
    logic    is_store;
    int      waited;
    kind     = alu_op_t'(code);
    is_store = (kind == op_store_word) || (kind == op_store_byte);
    is_mem   = is_store || (kind == op_load_word) || (kind == op_load_byte);
    active    = 1'b1;
    op        = kind;
    rd        = dst;
    reg_write = wr;
    rs1_value = a;
    rs2_value = b;
    imm       = im;
    use_imm   = sel;
    // stall seen now decides the coming edge
    waited = 0;
    while (stall && waited < stall_limit)
    begin
      next_drive_point();
      waited++;
    end
    if (stall)
    begin
      $display("ERROR: stall stayed high for %0d cycles at %0t", stall_limit, $time);
      protocol_errors++;
      timed_out = 1'b1;
    end
    else
    begin
      next_drive_point();
      issued++;
      exp_data_q.push_back(data);
      exp_zero_q.push_back(zf);
      exp_rd_q.push_back(dst);
      // Stores never write a register
      exp_write_q.push_back(wr && !is_store);
      // Edge that sets wb_valid; it is seen high one edge later
      exp_edge_q.push_back(cycle + (is_mem ? mem_latency + 1 : 1));
      // Memory ops lock right away while ALU ops leave the port open
      assert (stall == is_mem)
      else
      begin
        $display("FAIL %0t stall got %b expected %b", $time, stall, is_mem);
        value_errors++;
      end
    end
    active = 1'b0;
  endtask

  // Writeback monitor
  // Compares in order against the expected queue
  always @(negedge clk)
  begin
    if (rst_n && wb_valid)
    begin
      if (exp_data_q.size() == 0)
      begin
        $display("ERROR: writeback at %0t with no operation outstanding", $time);
        protocol_errors++;
      end
      else
      begin
        e_data  = exp_data_q.pop_front();
        e_zero  = exp_zero_q.pop_front();
        e_rd    = exp_rd_q.pop_front();
        e_write = exp_write_q.pop_front();
        e_edge  = exp_edge_q.pop_front();
        wb_count++;
        assert (wb_data == e_data)
        else
        begin
          $display("FAIL %0t wb_data got %h expected %h", $time, wb_data, e_data);
          value_errors++;
        end
        assert (wb_zero == e_zero)
        else
        begin
          $display("FAIL %0t wb_zero got %b expected %b", $time, wb_zero, e_zero);
          value_errors++;
        end
        assert (wb_rd == e_rd)
        else
        begin
          $display("FAIL %0t wb_rd got %h expected %h", $time, wb_rd, e_rd);
          value_errors++;
        end
        assert (wb_write == e_write)
        else
        begin
          $display("FAIL %0t wb_write got %b expected %b", $time, wb_write, e_write);
          value_errors++;
        end
        assert (cycle == e_edge)
        else
        begin
          $display("FAIL %0t wb_valid edge got %0d expected %0d", $time, cycle, e_edge);
          timing_errors++;
        end
      end
    end
  end

  initial
  begin
    int                         fd;
    int                         status;
    int                         fields;
    int                         gap;
    int                         waited;
    string                      line;
    logic [3:0]                 f_op;
    logic [reg_index_width-1:0] f_rd;
    logic                       f_wr;
    logic [word_width-1:0]      f_rs1;
    logic [word_width-1:0]      f_rs2;
    logic [word_width-1:0]      f_imm;
    logic                       f_sel;
    logic [word_width-1:0]      f_data;
    logic                       f_zero;
    seed            = 12;
    value_errors    = 0;
    timing_errors   = 0;
    protocol_errors = 0;
    issued          = 0;
    wb_count        = 0;
    timed_out       = 1'b0;
    rst_n     = 1'b0;
    active    = 1'b0;
    op        = op_add;
    rs1_value = '0;
    rs2_value = '0;
    imm       = '0;
    use_imm   = 1'b0;
    rd        = '0;
    reg_write = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet port before the first issue
    repeat (3)
    begin
      @(negedge clk);
      assert (!wb_valid)
      else
      begin
        $display("FAIL %0t wb_valid got %b expected 0", $time, wb_valid);
        value_errors++;
      end
      assert (!stall)
      else
      begin
        $display("FAIL %0t stall got %b expected 0", $time, stall);
        value_errors++;
      end
    end
    next_drive_point();
    fd = $fopen("exec_mem_input.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: could not open exec_mem_input.txt");
      protocol_errors++;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        status = $fgets(line, fd);
        // Skip comment and blank lines
        if (status > 0 && line.len() > 1 && line[0] != "#")
        begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_rd, f_wr, f_rs1,
                           f_rs2, f_imm, f_sel, f_data, f_zero);
          if (fields != 9)
          begin
            $display("ERROR: stimulus line could not be parsed: %s", line);
            protocol_errors++;
          end
          else
          begin
            // Idle gap of 0 to 2 cycles
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) next_drive_point();
            issue_op(f_op, f_rd, f_wr, f_rs1, f_rs2, f_imm, f_sel, f_data, f_zero);
          end
        end
      end
      $fclose(fd);
    end
    if (issued == 0)
    begin
      $display("ERROR: no operation was issued");
      protocol_errors++;
    end
    // Let outstanding writebacks drain
    waited = 0;
    while (exp_data_q.size() != 0 && waited < drain_limit)
    begin
      next_drive_point();
      waited++;
    end
    if (exp_data_q.size() != 0)
    begin
      $display("ERROR: %0d operations never wrote back", exp_data_q.size());
      protocol_errors++;
    end
    // Room for a stray duplicate to show up
    repeat (4) next_drive_point();
    $display("Errors: value %0d, timing %0d, protocol %0d (%0d issued, %0d written back)",
             value_errors, timing_errors, protocol_errors, issued, wb_count);
    if (value_errors + timing_errors + protocol_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: exec_mem_input.txt
# op rd reg_write rs1_value rs2_value imm use_imm exp_wb_data exp_wb_zero, all hex
# op: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl 8 lw 9 lb a sw b sb
0 01 1 00000005 00000007 00000000 0 0000000c 0
0 02 1 00000010 deadbeef fffffff0 1 00000000 1
1 03 1 12345678 12345678 00000000 0 00000000 1
1 04 1 00000064 00000000 00000014 1 00000050 0
2 05 1 f0f0ffff 0ff00f0f 00000000 0 00f00f0f 0
2 06 1 0000ff00 00000000 000000ff 1 00000000 1
3 07 1 12000034 00560000 00000000 0 12560034 0
3 08 1 a0000000 00000000 0000000a 1 a000000a 0
4 09 1 aaaaaaaa 55555555 00000000 0 ffffffff 0
4 0a 1 13579bdf 00000000 13579bdf 1 00000000 1
5 0b 1 ffffffff 00000001 00000000 0 00000001 0
5 0c 1 00000005 00000000 fffffffe 1 00000000 1
6 0d 1 00000003 00000004 00000000 0 00000030 0
6 0e 1 80000001 00000000 00000021 1 00000002 0
7 0f 1 80000000 0000001f 00000000 0 00000001 0
7 10 1 f0000000 00000000 00000004 1 0f000000 0
a 00 1 00000008 11223344 00000008 0 00000010 0
8 11 1 00000008 ffffffff 00000008 0 11223344 0
b 00 1 00000010 000000ab 00000002 0 00000012 0
8 12 1 00000000 00000000 00000010 0 11ab3344 0
9 13 1 00000012 00000000 00000000 0 000000ab 0
9 14 1 00000010 00000000 00000000 0 00000044 0
0 15 1 00000001 00000001 00000000 0 00000002 0
a 00 0 00000000 cafef00d 00000000 0 00000000 1
8 16 1 00000000 00000000 00000000 0 cafef00d 1
1 17 1 00000001 00000002 00000000 0 ffffffff 0
9 18 1 00000013 00000000 00000000 0 00000011 0
5 19 1 00000007 00000007 00000000 0 00000000 1

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exec_mem -f compile.f -o sim_exec_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_exec_mem > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
exit 1

// File: compile.f
exec_pkg.sv
alu.sv
execute_stage.sv
ex_mem_reg.sv
data_mem.sv
mem_stage.sv
exec_mem_top.sv
tb_exec_mem.sv
